/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_me_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+common
common/me_pkg.sv
common/window_if.sv
me_engine/search_window_feeder.sv
me_engine/pe_row.sv
me_engine/sad_tree.sv
me_engine/min_sad_tracker.sv
design/me_top.sv
tests/tb_me_top.sv

/* common/me_config.svh */
`ifndef ME_CONFIG_SVH
`define ME_CONFIG_SVH

// block edge in pixels
`define ME_BLOCK_DIM 4

// luma sample width
`define ME_PIXEL_W 8

// full block sad wide enough for N*N*255
`define ME_SAD_W 16

// candidate ordinal
`define ME_IDX_W 12

`endif

/* common/me_pkg.sv */
package me_pkg;

`include "me_config.svh"

    typedef logic [`ME_PIXEL_W-1:0] pixel_t;

    // sum of N absolute differences with room for N up to 16
    typedef logic [`ME_PIXEL_W+3:0] row_sum_t;

    typedef logic [`ME_SAD_W-1:0] sad_t;

    // window step applied on en_spr
    typedef enum logic [1:0]
    {
        shift_left_in    = 2'b00,
        shift_left_spare = 2'b01,
        shift_down       = 2'b10,
        shift_up         = 2'b11
    } shift_mode_t;

endpackage

/* common/window_if.sv */
`timescale 1ns/1ns
`include "me_config.svh"

interface window_if;
    import me_pkg::*;

    logic        en_spr;
    shift_mode_t mode;
    pixel_t      col_in [0:`ME_BLOCK_DIM-1];   // right end entry, one per row
    pixel_t      row_in [0:`ME_BLOCK_DIM-1];   // vertical entry row

    modport feeder
    (
        output en_spr,
        output mode,
        output col_in,
        output row_in
    );

    modport row
    (
        input en_spr,
        input mode,
        input col_in,
        input row_in
    );

endinterface

/* design/me_top.sv */
`timescale 1ns/1ns
`include "me_config.svh"

module me_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en_spr,
    input  logic                   en_cpr,
    input  logic                   valid,
    input  logic [1:0]             sel,
    input  logic [`ME_PIXEL_W-1:0] pixel_spr_in [0:`ME_BLOCK_DIM],
    input  logic [`ME_PIXEL_W-1:0] pixel_cpr_in [0:`ME_BLOCK_DIM-1],
    output logic [`ME_SAD_W-1:0]   min_sad,
    output logic [`ME_IDX_W-1:0]   best_idx
);
    import me_pkg::*;

    localparam int N = `ME_BLOCK_DIM;

    window_if win ();

    pixel_t   row_pix [0:N-1][0:N-1];   // search array, row by row
    row_sum_t row_sum [0:N-1];
    sad_t     sad;
    logic     sad_valid;

    search_window_feeder u_feeder
    (
        .clk          ( clk                ),
        .rst          ( rst                ),
        .en_spr       ( en_spr             ),
        .sel          ( shift_mode_t'(sel) ),
        .pixel_spr_in ( pixel_spr_in       ),
        .win          ( win                )
    );

    for (genvar r = 0; r < N; r++)
    begin : g_row
        pixel_t above [0:N-1];
        pixel_t below [0:N-1];

        if (r == 0)
        begin : g_above_edge
            assign above = win.row_in;   // enters on shift down
        end
        else
        begin : g_above_row
            assign above = row_pix[r-1];
        end

        if (r == N-1)
        begin : g_below_edge
            assign below = win.row_in;   // enters on shift up
        end
        else
        begin : g_below_row
            assign below = row_pix[r+1];
        end

        pe_row #
        (
            .ROW ( r )
        )
        u_pe_row
        (
            .clk          ( clk             ),
            .rst          ( rst             ),
            .win          ( win             ),
            .en_cpr       ( en_cpr          ),
            .pixel_cpr_in ( pixel_cpr_in[r] ),
            .above        ( above           ),
            .below        ( below           ),
            .row_pix      ( row_pix[r]      ),
            .row_sum      ( row_sum[r]      )
        );
    end

    sad_tree u_sad_tree
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .row_sum   ( row_sum   ),
        .valid     ( valid     ),
        .sad       ( sad       ),
        .sad_valid ( sad_valid )
    );

    min_sad_tracker u_tracker
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .clear     ( en_cpr    ),   // new block restarts the search
        .sad       ( sad       ),
        .sad_valid ( sad_valid ),
        .min_sad   ( min_sad   ),
        .best_idx  ( best_idx  )
    );

endmodule

/* me_engine/min_sad_tracker.sv */
`timescale 1ns/1ns
`include "me_config.svh"

module min_sad_tracker
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  me_pkg::sad_t         sad,
    input  logic                 sad_valid,
    output me_pkg::sad_t         min_sad,
    output logic [`ME_IDX_W-1:0] best_idx
);
    import me_pkg::*;

    logic [`ME_IDX_W-1:0] cand_cnt;   // ordinal of the next candidate
    logic                 better;

    // strict compare so a tie keeps the earlier candidate
    assign better = sad_valid && (sad < min_sad);

    always_ff @(posedge clk)
    begin
        if (rst || clear)
        begin
            min_sad  <= '1;
            best_idx <= '0;
            cand_cnt <= '0;
        end
        else
        begin
            if (sad_valid)
            begin
                cand_cnt <= cand_cnt + 1'b1;
            end
            if (better)
            begin
                min_sad  <= sad;
                best_idx <= cand_cnt;
            end
        end
    end

    // new block load must not overlap candidates still in the pipe
    a_no_valid_on_clear: assert property (@(posedge clk) disable iff (rst)
        !(sad_valid && clear))
        else $error("candidate sad arrived during block load");

endmodule

/* me_engine/pe_row.sv */
`timescale 1ns/1ns
`include "me_config.svh"

module pe_row #
(
    parameter int ROW = 0
)
(
    input  logic             clk,
    input  logic             rst,
    window_if.row            win,
    input  logic             en_cpr,
    input  me_pkg::pixel_t   pixel_cpr_in,
    input  me_pkg::pixel_t   above   [0:`ME_BLOCK_DIM-1],
    input  me_pkg::pixel_t   below   [0:`ME_BLOCK_DIM-1],
    output me_pkg::pixel_t   row_pix [0:`ME_BLOCK_DIM-1],
    output me_pkg::row_sum_t row_sum
);
    import me_pkg::*;

    localparam int N = `ME_BLOCK_DIM;

    pixel_t   cur      [0:N-1];   // current block row
    pixel_t   left_src [0:N-1];
    pixel_t   spr_nxt  [0:N-1];
    pixel_t   ad       [0:N-1];
    row_sum_t ad_sum;

    // current block loads column by column from the right
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cur <= '{default: '0};
        end
        else if (en_cpr)
        begin
            for (int c = 0; c < N-1; c++)
                cur[c] <= cur[c+1];
            cur[N-1] <= pixel_cpr_in;
        end
    end

    for (genvar c = 0; c < N-1; c++)
    begin : g_left
        assign left_src[c] = row_pix[c+1];
    end
    assign left_src[N-1] = win.col_in[ROW];

    always_comb
    begin
        for (int c = 0; c < N; c++)
        begin
            unique case (win.mode)
                shift_down: spr_nxt[c] = above[c];
                shift_up:   spr_nxt[c] = below[c];
                default:    spr_nxt[c] = left_src[c];   // both left modes
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            row_pix <= '{default: '0};
        end
        else if (win.en_spr)
        begin
            row_pix <= spr_nxt;
        end
    end

    for (genvar c = 0; c < N; c++)
    begin : g_ad
        assign ad[c] = (cur[c] > row_pix[c]) ? cur[c] - row_pix[c] : row_pix[c] - cur[c];
    end

    always_comb
    begin
        ad_sum = '0;
        for (int c = 0; c < N; c++)
            ad_sum = ad_sum + row_sum_t'(ad[c]);
    end

    always_ff @(posedge clk)
    begin
        row_sum <= ad_sum;   // first pipe stage
    end

endmodule

/* me_engine/sad_tree.sv */
`timescale 1ns/1ns
`include "me_config.svh"

module sad_tree
(
    input  logic             clk,
    input  logic             rst,
    input  me_pkg::row_sum_t row_sum [0:`ME_BLOCK_DIM-1],
    input  logic             valid,
    output me_pkg::sad_t     sad,
    output logic             sad_valid
);
    import me_pkg::*;

    localparam int N       = `ME_BLOCK_DIM;
    localparam int MAX_SAD = N * N * ((1 << `ME_PIXEL_W) - 1);

    sad_t total;
    logic valid_q;   // lines up with the row sum register

    if ((1 << `ME_SAD_W) <= MAX_SAD)
    begin : g_width_check
        $error("sad width too small for block size");
    end

    always_comb
    begin
        total = '0;
        for (int r = 0; r < N; r++)
            total = total + sad_t'(row_sum[r]);
    end

    always_ff @(posedge clk)
    begin
        sad <= total;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q   <= 1'b0;
            sad_valid <= 1'b0;
        end
        else
        begin
            valid_q   <= valid;
            sad_valid <= valid_q;
        end
    end

    // a larger total means a row sum was corrupted upstream
    a_sad_bound: assert property (@(posedge clk) disable iff (rst)
        sad_valid |-> (sad <= sad_t'(MAX_SAD)))
        else $error("sad total %0h above block maximum", sad);

endmodule

/* me_engine/search_window_feeder.sv */
`timescale 1ns/1ns
`include "me_config.svh"

module search_window_feeder
(
    input  logic                clk,
    input  logic                rst,
    input  logic                en_spr,
    input  me_pkg::shift_mode_t sel,
    input  me_pkg::pixel_t      pixel_spr_in [0:`ME_BLOCK_DIM],
    window_if.feeder            win
);
    import me_pkg::*;

    localparam int N = `ME_BLOCK_DIM;

    pixel_t spare     [0:N-1];
    pixel_t spare_nxt [0:N-1];
    pixel_t chain     [0:N+1];   // spare column with entry taps at both ends

    assign chain[0]   = pixel_spr_in[N];
    assign chain[N+1] = pixel_spr_in[N];

    for (genvar i = 0; i < N; i++)
    begin : g_chain
        assign chain[i+1]   = spare[i];
        assign spare_nxt[i] = sel[0] ? chain[i+2] : chain[i];   // up when sel[0] is set
    end

    // spare column only moves on vertical steps
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            spare <= '{default: '0};
        end
        else if (en_spr && sel[1])
        begin
            spare <= spare_nxt;
        end
    end

    always_comb
    begin
        win.en_spr = en_spr;
        win.mode   = sel;
        for (int r = 0; r < N; r++)
        begin
            win.col_in[r] = (sel == shift_left_spare) ? spare[r] : pixel_spr_in[r];
            win.row_in[r] = pixel_spr_in[r];
        end
    end

    a_mode_known: assert property (@(posedge clk) disable iff (rst)
        en_spr |-> !$isunknown(sel))
        else $error("shift mode unknown while en_spr is high");

endmodule

/* tests/tb_me_top.sv */
`timescale 1ns/1ns
`include "me_config.svh"

module tb_me_top;
    import me_pkg::*;

    localparam int N       = `ME_BLOCK_DIM;
    localparam int TIMEOUT = 40;   // cycles per wait loop

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 en_spr = 1'b0;
    logic                 en_cpr = 1'b0;
    logic                 valid = 1'b0;
    logic [1:0]           sel = 2'b00;
    pixel_t               pixel_spr_in [0:N] = '{default: '0};
    pixel_t               pixel_cpr_in [0:N-1] = '{default: '0};
    sad_t                 min_sad;
    logic [`ME_IDX_W-1:0] best_idx;

    // reference model of block, window, spare column and tracker
    pixel_t               spr_next [0:N];
    pixel_t               cpr_next [0:N-1];
    pixel_t               m_cur [0:N-1][0:N-1];
    pixel_t               m_win [0:N-1][0:N-1];
    pixel_t               m_spare [0:N-1];
    sad_t                 m_min = '1;
    sad_t                 last_sad;
    sad_t                 d1_min, d2_min, d3_min;
    logic [`ME_IDX_W-1:0] m_idx = '0;
    logic [`ME_IDX_W-1:0] m_cnt = '0;
    logic [`ME_IDX_W-1:0] d1_idx, d2_idx, d3_idx;
    logic                 v1, v2;
    int                   errors = 0;
    int                   tests = 0;

    me_top uut (.*);

    always #50 clk = ~clk;

    initial
    begin
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
    end

    // expected outputs trail the model by the 3 cycle pipe
    always @(posedge clk)
    begin
        if (rst || en_cpr)
        begin
            {d1_min, d2_min, d3_min} <= {3{m_min}};
            {d1_idx, d2_idx, d3_idx} <= {3{m_idx}};
            {v1, v2}                 <= 2'b00;
        end
        else
        begin
            {d1_min, d2_min, d3_min} <= {m_min, d1_min, d2_min};
            {d1_idx, d2_idx, d3_idx} <= {m_idx, d1_idx, d2_idx};
            {v1, v2}                 <= {valid, v1};
        end
    end

    a_min_sad: assert property (@(negedge clk) disable iff (rst) min_sad == d3_min)
        else
        begin
            errors = errors + 1;
            $display("mismatch min_sad exp=%h got=%h", d3_min, min_sad);
        end

    a_best_idx: assert property (@(negedge clk) disable iff (rst) best_idx == d3_idx)
        else
        begin
            errors = errors + 1;
            $display("mismatch best_idx exp=%h got=%h", d3_idx, best_idx);
        end

    task automatic check_eq(input string name, input int exp, input int got);
        assert (exp == got)
        else
        begin
            errors = errors + 1;
            $display("mismatch %s exp=%h got=%h", name, exp, got);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests %0d, errors %0d", tests, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic randomize_next();
        for (int i = 0; i <= N; i++)
            spr_next[i] = pixel_t'($urandom);
        for (int i = 0; i < N; i++)
            cpr_next[i] = pixel_t'($urandom);
    endtask

    task automatic score_candidate();
        int acc;
        int diff;
        acc = 0;
        for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
            begin
                diff = int'(m_cur[r][c]) - int'(m_win[r][c]);
                acc  = acc + ((diff < 0) ? -diff : diff);
            end
        last_sad = sad_t'(acc);
        if (last_sad < m_min)   // earlier candidate wins a tie
        begin
            m_min = last_sad;
            m_idx = m_cnt;
        end
        m_cnt++;
    endtask

    task automatic shift_model(input shift_mode_t mode);
        pixel_t old_win [0:N-1][0:N-1];
        pixel_t old_sp  [0:N-1];
        old_win = m_win;
        old_sp  = m_spare;
        for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++)
                case (mode)
                    shift_down: m_win[r][c] = (r > 0) ? old_win[r-1][c] : spr_next[c];
                    shift_up:   m_win[r][c] = (r < N-1) ? old_win[r+1][c] : spr_next[c];
                    default:    m_win[r][c] = (c < N-1) ? old_win[r][c+1] :
                                    ((mode == shift_left_in) ? spr_next[r] : old_sp[r]);
                endcase
        for (int i = 0; i < N; i++)
            if (mode == shift_down)
                m_spare[i] = (i > 0) ? old_sp[i-1] : spr_next[N];
            else if (mode == shift_up)
                m_spare[i] = (i < N-1) ? old_sp[i+1] : spr_next[N];
    endtask

    // one cycle of stimulus with the model following the same edge
    task automatic step(input logic do_spr, input shift_mode_t mode, input logic do_cpr,
                        input logic do_valid);
        @(posedge clk);
        #5;
        en_spr       = do_spr;
        sel          = mode;
        en_cpr       = do_cpr;
        valid        = do_valid;
        pixel_spr_in = spr_next;
        pixel_cpr_in = cpr_next;
        if (do_valid)
            score_candidate();   // window as held before this cycle's shift
        if (do_spr)
            shift_model(mode);
        if (do_cpr)
        begin
            for (int r = 0; r < N; r++)
            begin
                for (int c = 0; c < N-1; c++)
                    m_cur[r][c] = m_cur[r][c+1];
                m_cur[r][N-1] = cpr_next[r];
            end
            m_min = '1;
            m_idx = '0;
            m_cnt = '0;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        do
        begin
            step(1'b0, shift_left_in, 1'b0, 1'b0);
            n++;
        end
        while ((v1 || v2) && n < TIMEOUT);
        if (v1 || v2)
            abort_run("timeout: candidates still in the pipeline");
        @(negedge clk);
        check_eq("min_sad", m_min, min_sad);
        check_eq("best_idx", m_idx, best_idx);
    endtask

    task automatic load_block();
        drain();
        for (int c = 0; c < N; c++)
        begin
            randomize_next();
            step(1'b0, shift_left_in, 1'b1, 1'b0);
        end
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    initial
    begin
        int n;
        void'($urandom(93534));
        spr_next = '{default: '0};
        cpr_next = '{default: '0};
        m_cur    = '{default: '{default: '0}};
        m_win    = '{default: '{default: '0}};
        m_spare  = '{default: '0};
        n = 0;
        while (rst && n < TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (rst)
            abort_run("timeout: reset never released");

        drain();
        check_eq("min_sad", 16'hffff, min_sad);
        check_eq("best_idx", 0, best_idx);
        test_done("reset state");

        load_block();
        for (int c = 0; c < N; c++)
        begin
            for (int r = 0; r < N; r++)
                spr_next[r] = m_cur[r][c];   // window copies the block
            step(1'b1, shift_left_in, 1'b0, 1'b0);
        end
        step(1'b0, shift_left_in, 1'b0, 1'b1);
        drain();
        check_eq("min_sad", 0, min_sad);
        check_eq("best_idx", 0, best_idx);
        test_done("identical window");

        load_block();
        for (int band = 0; band < 4; band++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                randomize_next();
                step(1'b1, shift_left_in, 1'b0, $urandom_range(1) == 1);
            end
            randomize_next();
            step(1'b1, (band % 2 == 1) ? shift_up : shift_down, 1'b0, 1'b1);
        end
        drain();
        test_done("snake scan");

        load_block();
        for (int k = 0; k < 2*N; k++)
        begin
            randomize_next();
            step(1'b1, (k % 3 == 2) ? shift_up : shift_down, 1'b0, 1'b0);
        end
        for (int k = 0; k <= N; k++)
        begin
            randomize_next();
            step(1'b1, shift_left_spare, 1'b0, 1'b1);
        end
        drain();
        test_done("spare column");

        load_block();
        for (int k = 0; k < 4*N; k++)
        begin
            randomize_next();
            step(1'b1, shift_mode_t'(2'($urandom_range(3))), 1'b0, 1'b1);
        end
        drain();
        test_done("back to back");

        load_block();
        @(negedge clk);
        check_eq("min_sad", 16'hffff, min_sad);
        check_eq("best_idx", 0, best_idx);
        step(1'b0, shift_left_in, 1'b0, 1'b1);
        step(1'b0, shift_left_in, 1'b0, 1'b1);   // same window again for a tie
        drain();
        check_eq("min_sad", last_sad, min_sad);
        check_eq("best_idx", 0, best_idx);
        test_done("new block clear");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
